/* tour_params.svh */
////////////////////
// Tour length, board size and move executor timing for the knight tour
// replay design. Include this file in any module that needs the values.
////////////////////
`ifndef TOUR_PARAMS_SVH
`define TOUR_PARAMS_SVH

// Moves in one full tour of the 5x5 board.
`define TOUR_LEN 24

// Board edge in squares.
`define BOARD_DIM 5

// Executor busy cycles per square travelled.
`define CYC_PER_SQUARE 4
`define FANFARE_CYC 6  // Extra cycles when the fanfare plays.

`endif

/* knight_pkg.sv */
////////////////////
// Shared types for the knight tour replay design: vector widths, the
// board command, opcodes, headings, response bytes and sequencer states.
// Modules reference these by scoped name.
////////////////////
package knight_pkg;

  typedef logic [7:0] move_t;     // One-hot knight move.
  typedef logic [4:0] mv_indx_t;  // Index into the move store.
  typedef logic [7:0] heading_t;  // Heading vector.
  typedef logic [3:0] sq_cnt_t;   // Squares to travel.
  typedef logic [2:0] coord_t;    // Board coordinate.
  typedef logic [3:0] opcode_t;
  typedef logic [7:0] resp_t;     // Response byte to the host.

  ////////////////////
  // Headings
  ////////////////////
  localparam heading_t HEAD_NORTH = 8'h00;
  localparam heading_t HEAD_WEST  = 8'h3F;
  localparam heading_t HEAD_SOUTH = 8'h7F;
  localparam heading_t HEAD_EAST  = 8'hBF;

  // Opcodes. Anything else completes as a no-op.
  localparam opcode_t OP_MOVE         = 4'h4;
  localparam opcode_t OP_MOVE_FANFARE = 4'h5;
  localparam opcode_t OP_SET_POS      = 4'h6;  // Low six bits hold x then y.

  localparam resp_t RESP_DONE = 8'hA5;  // Command or whole tour finished.
  localparam resp_t RESP_BUSY = 8'h5A;  // Tour leg done, more to come.

  // Board command of 16 bits.
  typedef struct packed {
    opcode_t  opcode;
    heading_t heading;
    sq_cnt_t  sq_cnt;
  } cmd_t;

  // Tour sequencer states.
  typedef enum logic [2:0] {IDLE, VERT, HOLD_V, HORZ, HOLD_H} tour_seq_state_t;

endpackage

/* tour_move_store.sv */
////////////////////
// Move store for the tour. Holds TOUR_LEN one-hot knight moves written
// through the load port. The sequencer reads by index, combinationally.
////////////////////
`timescale 1ns/1ns
`include "tour_params.svh"

module tour_move_store (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_valid,  // Write strobe without a ready.
  input  knight_pkg::mv_indx_t load_addr,
  input  knight_pkg::move_t    load_move,
  input  knight_pkg::mv_indx_t mv_indx,     // Read index from the sequencer.
  output knight_pkg::move_t    move
);

  knight_pkg::move_t mem [`TOUR_LEN];  // Move array.

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `TOUR_LEN; i++) begin
        mem[i] <= '0;  // Empty tour after reset.
      end
    end else if (load_valid) begin
      mem[load_addr] <= load_move;  // Takes effect at this edge.
    end
  end

  // Read port. Indexes past the tour read as no move.
  assign move = (mv_indx < `TOUR_LEN) ? mem[mv_indx] : '0;

  ////////////////////
  // Load checks
  ////////////////////
  a_load_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    load_valid |-> $onehot(load_move))
    else $error("Loaded move %h is not one-hot.", load_move);

  a_load_addr : assert property (@(posedge clk) disable iff (!rst_n)
    load_valid |-> (load_addr < `TOUR_LEN))
    else $error("Load address %0d is past the tour.", load_addr);

endmodule

/* tour_cmd.sv */
////////////////////
// Tour sequencer. Splits each stored move into a vertical then a
// horizontal board command and shares the executor channel with host
// commands. Host has the channel only while the sequencer is idle.
// Also picks the response byte for each completion.
////////////////////
`timescale 1ns/1ns
`include "tour_params.svh"

module tour_cmd (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_tour,
  input  knight_pkg::cmd_t     host_cmd,
  input  logic                 host_valid,
  output logic                 host_ready,
  output knight_pkg::mv_indx_t mv_indx,     // Move store read index.
  input  knight_pkg::move_t    move,
  output knight_pkg::cmd_t     exec_cmd,
  output logic                 exec_valid,
  input  logic                 exec_ready,
  input  logic                 exec_done,   // One-cycle completion pulse.
  output knight_pkg::resp_t    resp,
  output logic                 tour_busy
);

  knight_pkg::tour_seq_state_t state;
  knight_pkg::tour_seq_state_t nxt_state;
  knight_pkg::heading_t        vert_head;
  knight_pkg::heading_t        horz_head;
  knight_pkg::sq_cnt_t         vert_cnt;
  knight_pkg::sq_cnt_t         horz_cnt;
  knight_pkg::cmd_t            tour_leg;       // Command offered by the tour.
  logic                        leg_horz;       // Horizontal leg selected.
  logic                        last_move;      // Index at final move.
  logic                        start_go;       // Start request accepted.
  logic                        host_inflight;  // Host command not yet done.
  logic                        host_xfer;

  assign last_move = (mv_indx == knight_pkg::mv_indx_t'(`TOUR_LEN - 1));
  assign start_go  = (state == knight_pkg::IDLE) && start_tour && !host_inflight;
  assign leg_horz  = (state == knight_pkg::HORZ) || (state == knight_pkg::HOLD_H);
  assign tour_busy = (state != knight_pkg::IDLE);

  ////////////////////
  // Move index
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mv_indx <= '0;
    end else if (start_go) begin
      mv_indx <= '0;  // Replay always begins at move 0.
    end else if ((state == knight_pkg::HOLD_H) && exec_done && !last_move) begin
      mv_indx <= mv_indx + 1'b1;  // Next move once the L is finished.
    end
  end

  // Move decoder. North adds to y, east adds to x.
  always_comb begin
    vert_head = knight_pkg::HEAD_NORTH;
    horz_head = knight_pkg::HEAD_EAST;
    vert_cnt  = 4'd0;  // No travel if the move is not one-hot.
    horz_cnt  = 4'd0;
    case (move)
      8'b0000_0001: begin                                       // N2 E1.
        vert_cnt  = 4'd2;
        horz_cnt  = 4'd1;
      end
      8'b0000_0010: begin                                       // N2 W1.
        vert_cnt  = 4'd2;
        horz_head = knight_pkg::HEAD_WEST;
        horz_cnt  = 4'd1;
      end
      8'b0000_0100: begin                                       // N1 W2.
        vert_cnt  = 4'd1;
        horz_head = knight_pkg::HEAD_WEST;
        horz_cnt  = 4'd2;
      end
      8'b0000_1000: begin                                       // S1 W2.
        vert_head = knight_pkg::HEAD_SOUTH;
        vert_cnt  = 4'd1;
        horz_head = knight_pkg::HEAD_WEST;
        horz_cnt  = 4'd2;
      end
      8'b0001_0000: begin                                       // S2 W1.
        vert_head = knight_pkg::HEAD_SOUTH;
        vert_cnt  = 4'd2;
        horz_head = knight_pkg::HEAD_WEST;
        horz_cnt  = 4'd1;
      end
      8'b0010_0000: begin                                       // S2 E1.
        vert_head = knight_pkg::HEAD_SOUTH;
        vert_cnt  = 4'd2;
        horz_cnt  = 4'd1;
      end
      8'b0100_0000: begin                                       // S1 E2.
        vert_head = knight_pkg::HEAD_SOUTH;
        vert_cnt  = 4'd1;
        horz_cnt  = 4'd2;
      end
      8'b1000_0000: begin                                       // N1 E2.
        vert_cnt  = 4'd1;
        horz_cnt  = 4'd2;
      end
      default: ;
    endcase
  end

  // The horizontal leg closes the L, so it carries the fanfare.
  assign tour_leg.opcode  = leg_horz ? knight_pkg::OP_MOVE_FANFARE : knight_pkg::OP_MOVE;
  assign tour_leg.heading = leg_horz ? horz_head : vert_head;
  assign tour_leg.sq_cnt  = leg_horz ? horz_cnt : vert_cnt;

  ////////////////////
  // Command mux
  ////////////////////
  always_comb begin
    if (state == knight_pkg::IDLE) begin
      exec_cmd   = host_cmd;
      exec_valid = host_valid && !host_inflight && !start_tour;  // Start wins a tie.
      host_ready = exec_ready && !host_inflight && !start_tour;
    end else begin
      exec_cmd   = tour_leg;
      exec_valid = (state == knight_pkg::VERT) || (state == knight_pkg::HORZ);
      host_ready = 1'b0;  // Host is held off for the whole tour.
    end
  end

  assign host_xfer = host_valid && host_ready;

  // One host command at a time. Cleared by its completion.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      host_inflight <= 1'b0;
    end else if (host_xfer) begin
      host_inflight <= 1'b1;
    end else if (exec_done) begin
      host_inflight <= 1'b0;
    end
  end

  ////////////////////
  // Sequencer FSM
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= knight_pkg::IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state = state;
    case (state)
      knight_pkg::IDLE:   if (start_go) nxt_state = knight_pkg::VERT;
      knight_pkg::VERT:   if (exec_ready) nxt_state = knight_pkg::HOLD_V;  // Leg taken.
      knight_pkg::HOLD_V: if (exec_done) nxt_state = knight_pkg::HORZ;
      knight_pkg::HORZ:   if (exec_ready) nxt_state = knight_pkg::HOLD_H;
      knight_pkg::HOLD_H: begin
        if (exec_done) begin
          nxt_state = last_move ? knight_pkg::IDLE : knight_pkg::VERT;
        end
      end
      default: nxt_state = knight_pkg::IDLE;
    endcase
  end

  // Only the last leg of the tour reports done. Host commands always do.
  assign resp = ((state == knight_pkg::HOLD_H) && last_move) || (state == knight_pkg::IDLE) ?
                knight_pkg::RESP_DONE : knight_pkg::RESP_BUSY;

  a_leg_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    (exec_valid && tour_busy) |-> $onehot(move))
    else $error("Tour leg offered from move %h at index %0d.", move, mv_indx);

  a_cmd_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (exec_valid && !exec_ready) |=> $stable(exec_cmd))
    else $error("Command changed while waiting for the executor.");

endmodule

/* move_exec.sv */
////////////////////
// Move executor. Accepts one board command at a time, stays busy for a
// time set by the square count and fanfare, then updates the knight
// position and pulses exec_done. Stands in for motor and sensor timing.
////////////////////
`timescale 1ns/1ns
`include "tour_params.svh"

module move_exec (
  input  logic               clk,
  input  logic               rst_n,
  input  knight_pkg::cmd_t   exec_cmd,
  input  logic               exec_valid,
  output logic               exec_ready,  // High only while idle.
  output logic               exec_done,   // Last busy cycle.
  output logic               fanfare,     // Pulse at fanfare acceptance.
  output knight_pkg::coord_t pos_x,
  output knight_pkg::coord_t pos_y
);

  knight_pkg::cmd_t cmd_q;      // Command being executed.
  logic             busy;
  logic [7:0]       busy_cnt;   // Cycles left, including this one.
  logic [7:0]       cyc_total;  // Busy time of the offered command.
  logic             exec_xfer;

  assign exec_ready = !busy;
  assign exec_xfer  = exec_valid && exec_ready;
  assign exec_done  = busy && (busy_cnt == 8'd1);
  assign fanfare    = exec_xfer && (exec_cmd.opcode == knight_pkg::OP_MOVE_FANFARE);

  // Travel time plus fanfare and at least one cycle.
  always_comb begin
    cyc_total = 8'(exec_cmd.sq_cnt * `CYC_PER_SQUARE);
    if (exec_cmd.opcode == knight_pkg::OP_MOVE_FANFARE) begin
      cyc_total = cyc_total + 8'(`FANFARE_CYC);
    end
    if (cyc_total == 8'd0) begin
      cyc_total = 8'd1;
    end
  end

  ////////////////////
  // Busy counter
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      busy_cnt <= '0;
    end else if (exec_xfer) begin
      busy     <= 1'b1;
      busy_cnt <= cyc_total;
    end else if (exec_done) begin
      busy <= 1'b0;  // Ready again next cycle.
    end else if (busy) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_xfer) cmd_q <= exec_cmd;  // Held for the whole move.
  end

  ////////////////////
  // Knight position
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pos_x <= '0;  // Knight starts in the corner.
      pos_y <= '0;
    end else if (exec_done) begin
      case (cmd_q.opcode)
        knight_pkg::OP_MOVE, knight_pkg::OP_MOVE_FANFARE: begin
          case (cmd_q.heading)
            knight_pkg::HEAD_NORTH: pos_y <= knight_pkg::coord_t'(pos_y + cmd_q.sq_cnt);
            knight_pkg::HEAD_SOUTH: pos_y <= knight_pkg::coord_t'(pos_y - cmd_q.sq_cnt);
            knight_pkg::HEAD_EAST:  pos_x <= knight_pkg::coord_t'(pos_x + cmd_q.sq_cnt);
            knight_pkg::HEAD_WEST:  pos_x <= knight_pkg::coord_t'(pos_x - cmd_q.sq_cnt);
            default: ;  // Unknown heading leaves the knight in place.
          endcase
        end
        knight_pkg::OP_SET_POS: begin
          pos_x <= cmd_q[5:3];
          pos_y <= cmd_q[2:0];
        end
        default: ;  // No-op still completes.
      endcase
    end
  end

  a_on_board : assert property (@(posedge clk) disable iff (!rst_n)
    (pos_x < `BOARD_DIM) && (pos_y < `BOARD_DIM))
    else $error("Knight left the board at (%0d,%0d).", pos_x, pos_y);

endmodule

/* knight_top.sv */
////////////////////
// Top level of the knight tour replay. Connects the move store, the tour
// sequencer and the move executor. Responses leave as a one-cycle pulse.
////////////////////
`timescale 1ns/1ns

module knight_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_valid,
  input  knight_pkg::mv_indx_t load_addr,
  input  knight_pkg::move_t    load_move,
  input  logic                 start_tour,
  input  knight_pkg::cmd_t     host_cmd,
  input  logic                 host_valid,
  output logic                 host_ready,
  output logic                 resp_valid,
  output knight_pkg::resp_t    resp,
  output logic                 tour_busy,
  output logic                 fanfare,
  output knight_pkg::coord_t   pos_x,
  output knight_pkg::coord_t   pos_y
);

  knight_pkg::mv_indx_t mv_indx;
  knight_pkg::move_t    move;
  knight_pkg::cmd_t     exec_cmd;  // Muxed command channel.
  logic                 exec_valid;
  logic                 exec_ready;
  logic                 exec_done;

  assign resp_valid = exec_done;  // Every completion sends one byte.

  tour_move_store u_tour_move_store (
    .clk, .rst_n, .load_valid, .load_addr, .load_move, .mv_indx, .move
  );

  tour_cmd u_tour_cmd (
    .clk, .rst_n, .start_tour, .host_cmd, .host_valid, .host_ready, .mv_indx, .move,
    .exec_cmd, .exec_valid, .exec_ready, .exec_done, .resp, .tour_busy
  );

  move_exec u_move_exec (
    .clk, .rst_n, .exec_cmd, .exec_valid, .exec_ready, .exec_done, .fanfare,
    .pos_x, .pos_y
  );

endmodule

/* tb_knight_top.sv */
////////////////////
// Testbench for the knight tour replay. Reads move loads, host commands,
// tour starts and expected positions from knight_stim.txt. Checks every
// response byte, fanfare pulse and position against its own board model.
////////////////////
`timescale 1ns/1ns
`include "tour_params.svh"

module tb_knight_top;

  localparam int WAIT_LIMIT = 200;  // Cycles before any wait gives up.

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 load_valid;
  knight_pkg::mv_indx_t load_addr;
  knight_pkg::move_t    load_move;
  logic                 start_tour;
  knight_pkg::cmd_t     host_cmd;
  logic                 host_valid;
  logic                 host_ready;
  logic                 resp_valid;
  knight_pkg::resp_t    resp;
  logic                 tour_busy;
  logic                 fanfare;
  knight_pkg::coord_t   pos_x;
  knight_pkg::coord_t   pos_y;

  knight_pkg::move_t moves [`TOUR_LEN];  // Copy of the loaded tour.
  int first_x [2 * `TOUR_LEN];           // Model positions from the first tour.
  int first_y [2 * `TOUR_LEN];
  int mx;                                // Model knight position.
  int my;
  int errors;
  int fan_seen;                          // Fanfare pulses since last response.
  int fan_total;
  int resp_total;                        // Response pulses seen on the port.
  int resp_expected;                     // One per host command, two per move.
  int tours;
  bit timed_out;

  always #2 clk = ~clk;  // 4 ns period.

  knight_top u_knight_top (
    .clk, .rst_n, .load_valid, .load_addr, .load_move, .start_tour, .host_cmd,
    .host_valid, .host_ready, .resp_valid, .resp, .tour_busy, .fanfare, .pos_x, .pos_y
  );

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  ////////////////////
  // Timing helpers
  ////////////////////
  task automatic sample_cycle();
    @(negedge clk);  // Outputs are settled mid-cycle.
    if (fanfare) fan_seen++;
    if (resp_valid) resp_total++;
    if (tour_busy) check(host_ready, 0, "host_ready during tour");
  endtask

  task automatic drive_point();
    @(posedge clk);
    #1;  // Inputs change just after the edge.
  endtask

  task automatic check_pos(input string what);
    check(pos_x, mx, {what, " pos_x"});
    check(pos_y, my, {what, " pos_y"});
  endtask

  // Waits for one response, then steps past the edge that moves the knight.
  task automatic wait_resp(input knight_pkg::resp_t exp_resp, input int exp_fan,
                           input string what);
    knight_pkg::tour_seq_state_t st;
    int n;
    n = 0;
    sample_cycle();
    while (!resp_valid && n < WAIT_LIMIT) begin
      sample_cycle();
      n++;
    end
    if (!resp_valid) begin
      st = u_knight_top.u_tour_cmd.state;
      $display("Timeout: no response for %s after %0d cycles, sequencer in %s",
               what, n, st.name());
      errors++;
      timed_out = 1'b1;
    end else begin
      check(resp, exp_resp, {what, " response byte"});
      check(fan_seen, exp_fan, {what, " fanfare pulses"});
      fan_total += fan_seen;
      fan_seen = 0;
      drive_point();
    end
  endtask

  ////////////////////
  // Board model
  ////////////////////
  // Knight move table. North adds to y, east adds to x.
  task automatic decode_move(input knight_pkg::move_t mv, output int dx, output int dy);
    case (mv)
      8'h01, 8'h02: dy = 2;
      8'h04, 8'h80: dy = 1;
      8'h08, 8'h40: dy = -1;
      8'h10, 8'h20: dy = -2;
      default: dy = 0;
    endcase
    case (mv)
      8'h01, 8'h20: dx = 1;
      8'h02, 8'h10: dx = -1;
      8'h04, 8'h08: dx = -2;
      8'h40, 8'h80: dx = 2;
      default: dx = 0;
    endcase
  endtask

  task automatic apply_host(input logic [15:0] w);
    if (w[15:12] == knight_pkg::OP_MOVE || w[15:12] == knight_pkg::OP_MOVE_FANFARE) begin
      case (w[11:4])
        knight_pkg::HEAD_NORTH: my += w[3:0];
        knight_pkg::HEAD_SOUTH: my -= w[3:0];
        knight_pkg::HEAD_EAST:  mx += w[3:0];
        knight_pkg::HEAD_WEST:  mx -= w[3:0];
        default: ;  // Unknown heading leaves the knight alone.
      endcase
    end else if (w[15:12] == knight_pkg::OP_SET_POS) begin
      mx = w[5:3];  // x then y in the low six bits.
      my = w[2:0];
    end
  endtask

  ////////////////////
  // Record handlers
  ////////////////////
  task automatic load_entry(input logic [4:0] addr, input knight_pkg::move_t mv);
    moves[addr] = mv;
    load_valid  = 1'b1;
    load_addr   = addr;
    load_move   = mv;
    drive_point();
    load_valid  = 1'b0;
  endtask

  task automatic run_host(input logic [15:0] w);
    int n;
    host_cmd   = w;
    host_valid = 1'b1;
    resp_expected++;
    n = 0;
    sample_cycle();
    while (!host_ready && n < WAIT_LIMIT) begin
      sample_cycle();
      n++;
    end
    if (!host_ready) begin
      $display("Timeout: host command %h was never accepted", w);
      errors++;
      timed_out = 1'b1;
    end else begin
      drive_point();  // Transfer happened at this edge.
      host_valid = 1'b0;
      wait_resp(knight_pkg::RESP_DONE, (w[15:12] == knight_pkg::OP_MOVE_FANFARE),
                $sformatf("host command %h", w));
      apply_host(w);
      if (!timed_out) check_pos($sformatf("host command %h", w));
    end
  endtask

  // Starts a tour while a host command is held, which must wait for the end.
  task automatic run_tour(input logic [15:0] pend);
    int  dx;
    int  dy;
    int  fan_start;
    bit  horz;
    host_cmd   = pend;
    host_valid = 1'b1;
    start_tour = 1'b1;
    fan_seen   = 0;
    resp_expected += 2 * `TOUR_LEN;
    sample_cycle();
    check(host_ready, 0, "host_ready in start cycle");  // Start wins the tie.
    drive_point();
    start_tour = 1'b0;
    check(tour_busy, 1, "tour_busy after start");
    fan_start = fan_total;
    for (int i = 0; i < 2 * `TOUR_LEN && !timed_out; i++) begin
      horz = (i % 2 == 1);  // Odd legs are horizontal.
      decode_move(moves[i / 2], dx, dy);
      wait_resp((i == 2 * `TOUR_LEN - 1) ? knight_pkg::RESP_DONE : knight_pkg::RESP_BUSY,
                horz, $sformatf("tour leg %0d", i));
      if (!timed_out) begin
        if (horz) begin
          mx += dx;
        end else begin
          my += dy;
        end
        check_pos($sformatf("tour leg %0d", i));
        if (tours == 0) begin
          first_x[i] = mx;  // Reference for the replay.
          first_y[i] = my;
        end else begin
          check(pos_x, first_x[i], $sformatf("replay leg %0d pos_x", i));
          check(pos_y, first_y[i], $sformatf("replay leg %0d pos_y", i));
        end
      end
    end
    if (!timed_out) begin
      check(tour_busy, 0, "tour_busy after final response");
      check(fan_total - fan_start, `TOUR_LEN, "fanfare pulses in tour");
      tours++;
      run_host(pend);  // Held command goes through once the tour is over.
    end
  endtask

  ////////////////////
  // Main flow
  ////////////////////
  initial begin
    logic [7:0]  kind;
    logic [4:0]  addr;
    logic [7:0]  mv;
    logic [15:0] word;
    int          fd;
    int          code;
    int          ex;
    int          ey;
    string       line;
    rst_n         = 1'b0;
    load_valid    = 1'b0;
    load_addr     = '0;
    load_move     = '0;
    start_tour    = 1'b0;
    host_cmd      = '0;
    host_valid    = 1'b0;
    errors        = 0;
    fan_seen      = 0;
    fan_total     = 0;
    resp_total    = 0;
    resp_expected = 0;
    tours         = 0;
    timed_out     = 1'b0;
    mx            = 0;
    my            = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) begin  // Quiet outputs after reset.
      sample_cycle();
      check(host_ready, 1, "host_ready after reset");
      check(tour_busy, 0, "tour_busy after reset");
      check(resp_valid, 0, "resp_valid after reset");
      check(fanfare, 0, "fanfare after reset");
      check_pos("reset");
    end
    drive_point();
    fd = $fopen("knight_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open knight_stim.txt for reading");
      errors++;
    end else begin
      while (!timed_out && $fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": code = $fgets(line, fd);  // Comment line.
          "L": begin
            code = $fscanf(fd, "%h %h", addr, mv);
            load_entry(addr, mv);
          end
          "H": begin
            code = $fscanf(fd, "%h", word);
            run_host(word);
          end
          "S": begin
            code = $fscanf(fd, "%h", word);
            run_tour(word);
          end
          "E": begin
            code = $fscanf(fd, "%d %d", ex, ey);
            check(pos_x, ex, "expected pos_x");
            check(pos_y, ey, "expected pos_y");
            check(mx, ex, "model x against file");
            check(my, ey, "model y against file");
          end
          default: begin
            $display("Unknown record kind '%c' in the stimulus file", kind);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    check(resp_total, resp_expected, "response count");
    $display("Summary: %0d errors, %0d responses, %0d fanfare pulses, %0d tours",
             errors, resp_total, fan_total, tours);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* knight_stim.txt */
# Columns: L addr move (hex), H host command word (hex), E expected x y (decimal).
# S word starts a tour and holds the host command word pending until it ends.
H 600A
H 4002
H 5BF2
H 47F3
H 43F1
H 9123
E 2 1
H 6000
E 0 0
L 00 80
L 01 40
L 02 02
L 03 01
L 04 08
L 05 04
L 06 20
L 07 20
L 08 80
L 09 02
L 0A 04
L 0B 10
L 0C 20
L 0D 80
L 0E 01
L 0F 04
L 10 08
L 11 20
L 12 40
L 13 01
L 14 02
L 15 08
L 16 10
L 17 80
S 4BF1
E 3 2
H 6000
S 9000
E 2 2

/* sim.f */
+incdir+.
knight_pkg.sv
tour_move_store.sv
tour_cmd.sv
move_exec.sv
knight_top.sv
tb_knight_top.sv
